// ==== rtl/trap_defs.svh ====
// limits are word addresses in 16-bit spaces, opcodes are the 7-bit major field
// mstatus only knows two values here, checks on and inside the handler
`ifndef TRAP_DEFS_SVH
`define TRAP_DEFS_SVH

`define MAX_ROM_ADDR     16'h01fc  // last legal pc
`define MAX_RAM_ADDR     16'h001f  // last legal data word

`define CSR_MSTATUS      12'h300
`define CSR_MTVEC        12'h305
`define CSR_MEPC         12'h341
`define CSR_MCAUSE       12'h342

// legal major opcodes
`define OP_LOAD          7'd3
`define OP_IMM           7'd19
`define OP_STORE         7'd35
`define OP_REG           7'd51
`define OP_BRANCH        7'd99
`define OP_JAL           7'd111
`define OP_SYSTEM        7'd115

// funct3 of the supported csr ops
`define F3_CSRRW         3'b001
`define F3_CSRRWI        3'b101

// whole-word system encodings
`define INSTR_ECALL      32'h00000073
`define INSTR_EBREAK     32'h00100073
`define INSTR_URET       32'h00200073

`define CAUSE_TYPE_EXC   1'b0  // interrupts never raised
`define CAUSE_PC_RANGE   7'd0
`define CAUSE_ILLEGAL    7'd2
`define CAUSE_BREAK      7'd3
`define CAUSE_DATA_RANGE 7'd4
`define CAUSE_ECALL      7'd11

`define MSTATUS_CHECK    8'h01  // checks enabled
`define MSTATUS_HANDLER  8'h10  // in handler, checks off

`endif

// ==== rtl/trap_pkg.sv ====
// shared types of the trap subsystem
// exc_info_t is {type, cause[6:0], mstatus[7:0], pc[15:0]}
package trap_pkg;

    // raw instruction or csr data
    typedef logic [31:0] word_t;

    // pc and data addresses are 16-bit word addresses
    typedef logic [15:0] addr_t;

    // csr number as found in instr[31:20]
    typedef logic [11:0] csr_addr_t;

    // mcause payload, no interrupt bit here
    typedef logic [6:0]  cause_t;

    // only low byte of mstatus is kept
    typedef logic [7:0]  status_t;

    // packed trap report
    //   [31]    cause type, 0 = exception
    //   [30:24] cause
    //   [23:16] mstatus after entry
    //   [15:0]  faulting pc
    typedef logic [31:0] exc_info_t;

    // handler residence tracked by the controller
    typedef enum logic {
        run,        // normal flow, checks follow mstatus
        in_handler  // trap taken, waiting for uret
    } ctrl_state_t;

endpackage

// ==== rtl/csr_bus_if.sv ====
// csr access and trap commands from controller to register file
// enter, leave and wr_en are one-cycle strobes, at most one high per cycle
interface csr_bus_if
    import trap_pkg::*;
();
    logic      wr_en;        // software write strobe
    csr_addr_t wr_addr;
    word_t     wr_data;
    csr_addr_t rd_addr;      // async read port
    word_t     rd_data;
    logic      enter;        // trap entry strobe
    cause_t    enter_cause;
    addr_t     enter_epc;
    logic      leave;        // uret strobe
    status_t   mstatus;      // live register values
    addr_t     mtvec;
    addr_t     mepc;

    modport ctrl (
        output wr_en, wr_addr, wr_data, rd_addr,
        output enter, enter_cause, enter_epc, leave,
        input  rd_data, mstatus, mtvec, mepc
    );

    modport regs (
        input  wr_en, wr_addr, wr_data, rd_addr,
        input  enter, enter_cause, enter_epc, leave,
        output rd_data, mstatus, mtvec, mepc
    );
endinterface

// ==== rtl/except_checker.sv ====
// purely combinational, checks only while mstatus is the checks-on value
// range checks are unsigned, so negative addresses count as too large
`include "trap_defs.svh"

module except_checker
    import trap_pkg::*;
(
    input  word_t     instr,
    input  addr_t     pc,
    input  addr_t     data_addr,
    input  status_t   mstatus,
    output logic      exc,       // level, valid in the same cycle
    output exc_info_t exc_info   // zero when no exception
);

    logic [6:0] opcode;
    logic       legal_op;   // one of the seven known majors
    logic       mem_op;     // load or store
    logic       checks_on;
    logic       hit;
    cause_t     cause;

    assign opcode = instr[6:0];

    assign legal_op = (opcode == `OP_LOAD)   ||
                      (opcode == `OP_IMM)    ||
                      (opcode == `OP_STORE)  ||
                      (opcode == `OP_REG)    ||
                      (opcode == `OP_BRANCH) ||
                      (opcode == `OP_JAL)    ||
                      (opcode == `OP_SYSTEM);

    assign mem_op    = (opcode == `OP_LOAD) || (opcode == `OP_STORE);
    assign checks_on = (mstatus == `MSTATUS_CHECK);

    // rules in rising priority, a later match overwrites the cause
    always_comb begin
        hit   = 1'b0;
        cause = `CAUSE_PC_RANGE;

        if (checks_on) begin
            // unknown major opcode
            if (!legal_op) begin
                hit   = 1'b1;
                cause = `CAUSE_ILLEGAL;
            end

            // load/store outside data space
            if (mem_op && (data_addr > `MAX_RAM_ADDR)) begin
                hit   = 1'b1;
                cause = `CAUSE_DATA_RANGE;
            end

            // fetch outside program space
            if (pc > `MAX_ROM_ADDR) begin
                hit   = 1'b1;
                cause = `CAUSE_PC_RANGE;
            end

            if (instr == `INSTR_ECALL) begin
                hit   = 1'b1;
                cause = `CAUSE_ECALL;
            end

            // ebreak beats everything
            if (instr == `INSTR_EBREAK) begin
                hit   = 1'b1;
                cause = `CAUSE_BREAK;
            end
        end
    end

    assign exc = hit;

    // mstatus field carries the value after trap entry
    assign exc_info = hit ? {`CAUSE_TYPE_EXC, cause, `MSTATUS_HANDLER, pc} : '0;

endmodule

// ==== rtl/csr_file.sv ====
// four machine csrs, unknown addresses read zero and drop writes
// enter, leave and wr_en are assumed exclusive, enter wins if not
`include "trap_defs.svh"

module csr_file
    import trap_pkg::*;
(
    input logic      clk,
    input logic      rst_n,
    csr_bus_if.regs  bus
);

    status_t mstatus;
    addr_t   mtvec;   // handler base
    addr_t   mepc;    // return pc
    cause_t  mcause;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mstatus <= `MSTATUS_CHECK;  // checks on out of reset
            mtvec   <= '0;
            mepc    <= '0;
            mcause  <= '0;
        end else if (bus.enter) begin
            // trap entry, save context and mask checks
            mepc    <= bus.enter_epc;
            mcause  <= bus.enter_cause;
            mstatus <= `MSTATUS_HANDLER;
        end else if (bus.leave) begin
            mstatus <= `MSTATUS_CHECK;  // uret re-arms checks
        end else if (bus.wr_en) begin
            // software write, truncated to field width
            case (bus.wr_addr)
                `CSR_MSTATUS: mstatus <= bus.wr_data[7:0];
                `CSR_MTVEC:   mtvec   <= bus.wr_data[15:0];
                `CSR_MEPC:    mepc    <= bus.wr_data[15:0];
                `CSR_MCAUSE:  mcause  <= bus.wr_data[6:0];
                default: ;  // unsupported csr, write dropped
            endcase
        end
    end

    // async read, zero extended to a word
    always_comb begin
        case (bus.rd_addr)
            `CSR_MSTATUS: bus.rd_data = {24'd0, mstatus};
            `CSR_MTVEC:   bus.rd_data = {16'd0, mtvec};
            `CSR_MEPC:    bus.rd_data = {16'd0, mepc};
            `CSR_MCAUSE:  bus.rd_data = {25'd0, mcause};
            default:      bus.rd_data = '0;
        endcase
    end

    // live values for checker and redirect
    assign bus.mstatus = mstatus;
    assign bus.mtvec   = mtvec;
    assign bus.mepc    = mepc;

endmodule

// ==== rtl/trap_ctrl.sv ====
// all results registered, one cycle after the sampling edge
// exceptions beat csr ops and uret, csrrw always returns the old value
`include "trap_defs.svh"

module trap_ctrl
    import trap_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      instr_valid,
    input  word_t     instr,
    input  word_t     rs1_data,
    input  logic      exc,
    input  exc_info_t exc_info,
    csr_bus_if.ctrl   bus,
    output logic      trap,            // pulse
    output exc_info_t trap_info,
    output logic      redirect_valid,  // pulse
    output addr_t     redirect_pc,
    output logic      rd_we,           // pulse
    output word_t     rd_data
);

    logic        is_system;
    logic [2:0]  funct3;
    csr_addr_t   csr_addr;
    logic        is_uret;
    logic        is_csrrw;
    logic        is_csrrwi;
    logic        do_trap;   // strobes to csr_file, mutually exclusive
    logic        do_leave;
    logic        do_write;
    word_t       wr_val;
    ctrl_state_t state;
    ctrl_state_t state_nxt;

    assign is_system = (instr[6:0] == `OP_SYSTEM);
    assign funct3    = instr[14:12];
    assign csr_addr  = instr[31:20];
    assign is_uret   = (instr == `INSTR_URET);
    assign is_csrrw  = is_system && (funct3 == `F3_CSRRW);
    assign is_csrrwi = is_system && (funct3 == `F3_CSRRWI);

    assign do_trap  = instr_valid && exc;
    assign do_leave = instr_valid && !exc && is_uret;
    assign do_write = instr_valid && !exc && (is_csrrw || is_csrrwi);

    // csrrwi takes the rs1 field as zero-extended immediate
    assign wr_val = is_csrrwi ? {27'd0, instr[19:15]} : rs1_data;

    assign bus.enter       = do_trap;
    assign bus.enter_cause = exc_info[30:24];
    assign bus.enter_epc   = exc_info[15:0];
    assign bus.leave       = do_leave;
    assign bus.wr_en       = do_write;
    assign bus.wr_addr     = csr_addr;
    assign bus.wr_data     = wr_val;
    assign bus.rd_addr     = csr_addr;  // old value read before the edge

    // follows mstatus, software may enter or leave handler mode too
    always_comb begin
        state_nxt = state;
        if (do_trap)
            state_nxt = in_handler;
        else if (do_leave)
            state_nxt = run;
        else if (do_write && (csr_addr == `CSR_MSTATUS))
            state_nxt = (wr_val[7:0] == `MSTATUS_HANDLER) ? in_handler : run;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state          <= run;
            trap           <= 1'b0;
            redirect_valid <= 1'b0;
            rd_we          <= 1'b0;
        end else begin
            state          <= state_nxt;
            trap           <= do_trap;
            redirect_valid <= do_trap || do_leave;  // trap and uret both jump
            rd_we          <= do_write;
        end
    end

    // payloads only meaningful with their pulse
    always_ff @(posedge clk) begin
        if (do_trap)
            trap_info <= exc_info;
        if (do_trap)
            redirect_pc <= bus.mtvec;  // handler entry
        else if (do_leave)
            redirect_pc <= bus.mepc;   // back to saved pc
        if (do_write)
            rd_data <= bus.rd_data;
    end

endmodule

// ==== rtl/trap_unit.sv ====
// trap and csr subsystem, one instruction per cycle, no back-pressure
// outputs are pulses one cycle after instr_valid was sampled
module trap_unit
    import trap_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      instr_valid,     // decode-stage strobe
    input  word_t     instr,
    input  addr_t     pc,
    input  addr_t     data_addr,       // only used by loads/stores
    input  word_t     rs1_data,
    output logic      trap,
    output exc_info_t trap_info,
    output logic      redirect_valid,
    output addr_t     redirect_pc,
    output logic      rd_we,
    output word_t     rd_data
);

    logic      exc;
    exc_info_t exc_info;

    csr_bus_if csr_bus ();

    // exception detection, gated by live mstatus
    except_checker i_except_checker (
        .instr     (instr),
        .pc        (pc),
        .data_addr (data_addr),
        .mstatus   (csr_bus.mstatus),
        .exc       (exc),
        .exc_info  (exc_info)
    );

    csr_file i_csr_file (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (csr_bus.regs)
    );

    trap_ctrl i_trap_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .instr_valid    (instr_valid),
        .instr          (instr),
        .rs1_data       (rs1_data),
        .exc            (exc),
        .exc_info       (exc_info),
        .bus            (csr_bus.ctrl),
        .trap           (trap),
        .trap_info      (trap_info),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .rd_we          (rd_we),
        .rd_data        (rd_data)
    );

endmodule

// ==== test/trap_unit_sva.sv ====
// pulse rules and reset values of trap_unit, bound to every instance
// state and mstatus are taken from inside the design by the bind
`include "trap_defs.svh"

module trap_unit_sva
    import trap_pkg::*;
(
    input logic        clk,
    input logic        rst_n,
    input logic        instr_valid,
    input logic        trap,
    input logic        redirect_valid,
    input logic        rd_we,
    input ctrl_state_t state,    // controller handler flag
    input status_t     mstatus   // live csr value
);
    timeunit 1ns;
    timeprecision 100ps;

    int unsigned fail_count = 0;  // assertion failures so far

    // a trap always jumps to the handler
    a_trap_redirect: assert property (@(posedge clk) disable iff (!rst_n)
        trap |-> redirect_valid)
    else begin
        fail_count++;
        $error("trap without redirect_valid");
    end

    a_trap_not_rd_we: assert property (@(posedge clk) disable iff (!rst_n)
        !(trap && rd_we))
    else begin
        fail_count++;
        $error("trap and rd_we high together");
    end

    // idle cycle gives no result one cycle later
    a_idle_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        !instr_valid |=> !(trap || redirect_valid || rd_we))
    else begin
        fail_count++;
        $error("pulse after instr_valid was low");
    end

    a_handler_status: assert property (@(posedge clk) disable iff (!rst_n)
        (state == in_handler) |-> (mstatus == `MSTATUS_HANDLER))
    else begin
        fail_count++;
        $error("in_handler while mstatus is not handler");
    end

    // reset clears pulses and arms checks
    a_reset_values: assert property (@(posedge clk)
        !rst_n |=> (!(trap || redirect_valid || rd_we) && mstatus == `MSTATUS_CHECK))
    else begin
        fail_count++;
        $error("wrong values after reset");
    end

endmodule

bind trap_unit trap_unit_sva i_trap_unit_sva (
    .clk            (clk),
    .rst_n          (rst_n),
    .instr_valid    (instr_valid),
    .trap           (trap),
    .redirect_valid (redirect_valid),
    .rd_we          (rd_we),
    .state          (i_trap_ctrl.state),
    .mstatus        (csr_bus.mstatus)
);

// ==== test/trap_unit_tb.sv ====
// random instruction mix against a csr and trap model, fixed seed
// inputs change 1 ns after the rising edge, results checked 1 ns after the next one
`include "trap_defs.svh"

module trap_unit_tb
    import trap_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_INSTR    = 600;
    localparam int RST_CYCLES = 8;
    localparam int MAX_CYCLES = 2 * (N_INSTR + RST_CYCLES) + 300;  // about 1500

    logic      clk = 1'b0;
    logic      rst_n;
    logic      instr_valid;
    word_t     instr;
    addr_t     pc;
    addr_t     data_addr;
    word_t     rs1_data;
    logic      trap;
    exc_info_t trap_info;
    logic      redirect_valid;
    addr_t     redirect_pc;
    logic      rd_we;
    word_t     rd_data;

    // model csrs
    status_t   m_mstatus;
    addr_t     m_mtvec;
    addr_t     m_mepc;
    cause_t    m_mcause;
    // expected result of the last driven instruction
    logic      exp_trap;
    logic      exp_redirect;
    logic      exp_rd_we;
    exc_info_t exp_info;
    addr_t     exp_rpc;
    word_t     exp_rd;

    integer      seed;
    int unsigned cycles = 0;

    trap_unit i_trap_unit (
        .clk            (clk),
        .rst_n          (rst_n),
        .instr_valid    (instr_valid),
        .instr          (instr),
        .pc             (pc),
        .data_addr      (data_addr),
        .rs1_data       (rs1_data),
        .trap           (trap),
        .trap_info      (trap_info),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .rd_we          (rd_we),
        .rd_data        (rd_data)
    );

    always #5 clk = ~clk;  // 10 ns period

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (i_trap_unit.i_trap_unit_sva.fail_count != 0) begin
            $display("a bound assertion failed, run stopped");
            $display("*** FAILED ***");
            $fatal(1, "assertion failed");
        end else if (cycles >= MAX_CYCLES) begin
            $display("run stopped, %0d cycles passed without reaching the end", cycles);
            $display("*** FAILED ***");
            $fatal(1, "timeout");
        end
    end

    task automatic report_error(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        $display("*** FAILED ***");
        $fatal(1, "mismatch");
    endtask

    task automatic check_pulse(input logic got, input logic exp, input string what);
        if (got !== exp)
            report_error($sformatf("%s is %b, expected %b", what, got, exp));
    endtask

    task automatic check_info(input exc_info_t got, input exc_info_t exp, input string what);
        if (got !== exp)
            report_error($sformatf("%s is %h, expected %h", what, got, exp));
    endtask

    task automatic check_pc(input addr_t got, input addr_t exp, input string what);
        if (got !== exp)
            report_error($sformatf("%s is %h, expected %h", what, got, exp));
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp)
            report_error($sformatf("%s is %h, expected %h", what, got, exp));
    endtask

    // model read, zero extended, unknown csr gives 0
    function automatic word_t csr_value(input csr_addr_t a);
        case (a)
            `CSR_MSTATUS: return {24'd0, m_mstatus};
            `CSR_MTVEC:   return {16'd0, m_mtvec};
            `CSR_MEPC:    return {16'd0, m_mepc};
            `CSR_MCAUSE:  return {25'd0, m_mcause};
            default:      return '0;
        endcase
    endfunction

    task automatic csr_store(input csr_addr_t a, input word_t d);
        case (a)
            `CSR_MSTATUS: m_mstatus = d[7:0];
            `CSR_MTVEC:   m_mtvec   = d[15:0];
            `CSR_MEPC:    m_mepc    = d[15:0];
            `CSR_MCAUSE:  m_mcause  = d[6:0];
            default: ;  // write ignored
        endcase
    endtask

    // expected outputs for the current inputs, model updated as at the edge
    task automatic predict();
        logic [6:0] op;
        logic [2:0] f3;
        logic       hit;
        cause_t     cause;
        op = instr[6:0];
        f3 = instr[14:12];
        hit = 1'b0;
        cause = '0;
        exp_trap = 1'b0;
        exp_redirect = 1'b0;
        exp_rd_we = 1'b0;
        if (instr_valid) begin
            if (m_mstatus == `MSTATUS_CHECK) begin  // later rule overrides
                if (!(op inside {`OP_LOAD, `OP_IMM, `OP_STORE, `OP_REG,
                                 `OP_BRANCH, `OP_JAL, `OP_SYSTEM})) begin
                    hit = 1'b1;
                    cause = `CAUSE_ILLEGAL;
                end
                if ((op == `OP_LOAD || op == `OP_STORE) && data_addr > `MAX_RAM_ADDR) begin
                    hit = 1'b1;
                    cause = `CAUSE_DATA_RANGE;
                end
                if (pc > `MAX_ROM_ADDR) begin
                    hit = 1'b1;
                    cause = `CAUSE_PC_RANGE;
                end
                if (instr == `INSTR_ECALL) begin
                    hit = 1'b1;
                    cause = `CAUSE_ECALL;
                end
                if (instr == `INSTR_EBREAK) begin
                    hit = 1'b1;
                    cause = `CAUSE_BREAK;
                end
            end
            if (hit) begin
                exp_trap = 1'b1;
                exp_info = {1'b0, cause, `MSTATUS_HANDLER, pc};
                exp_redirect = 1'b1;
                exp_rpc = m_mtvec;   // old mtvec
                m_mepc = pc;
                m_mcause = cause;
                m_mstatus = `MSTATUS_HANDLER;
            end else if (instr == `INSTR_URET) begin
                exp_redirect = 1'b1;
                exp_rpc = m_mepc;
                m_mstatus = `MSTATUS_CHECK;
            end else if (op == `OP_SYSTEM && (f3 == 3'b001 || f3 == 3'b101)) begin
                exp_rd_we = 1'b1;
                exp_rd = csr_value(instr[31:20]);  // old value
                csr_store(instr[31:20], (f3 == 3'b101) ? {27'd0, instr[19:15]} : rs1_data);
            end
        end
    endtask

    // weighted random instruction on all inputs
    task automatic drive_random();
        int        kind;
        int        sel;
        word_t     r;
        csr_addr_t ca;
        logic [6:0] op;
        logic [2:0] f3;
        logic [4:0] imm;
        r = $random(seed);
        kind = {$random(seed)} % 16;
        sel = {$random(seed)} % 6;
        instr_valid = ({$random(seed)} % 8) != 0;  // low about 1 in 8
        rs1_data = $random(seed);
        data_addr = $random(seed);
        if ({$random(seed)} % 8 == 0)
            pc = 16'h0200 | r[15:0];  // beyond program space
        else
            pc = addr_t'({$random(seed)} % 32'h01fd);
        case (kind)
            0, 1, 2, 3: begin  // plain alu and branch
                op = (kind == 0) ? `OP_IMM : (kind == 1) ? `OP_REG :
                     (kind == 2) ? `OP_BRANCH : `OP_JAL;
                instr = {r[31:7], op};
            end
            4, 5, 6: begin
                op = r[0] ? `OP_LOAD : `OP_STORE;
                instr = {r[31:7], op};
                if (r[1])
                    data_addr = data_addr & 16'h001f;  // in range
            end
            7:       instr = r;  // almost always an illegal opcode
            8:       instr = `INSTR_ECALL;
            9:       instr = `INSTR_EBREAK;
            10, 11:  instr = `INSTR_URET;
            default: begin  // csrrw / csrrwi
                case (sel)
                    0, 4:    ca = `CSR_MSTATUS;
                    1:       ca = `CSR_MTVEC;
                    2:       ca = `CSR_MEPC;
                    3:       ca = `CSR_MCAUSE;
                    default: ca = 12'h7c0;  // not implemented
                endcase
                f3 = r[3] ? 3'b101 : 3'b001;
                imm = r[8:4];
                if (ca == `CSR_MSTATUS && !r[10]) begin
                    imm = r[9] ? 5'd1 : 5'd16;  // checks on or handler
                    rs1_data = r[9] ? 32'h01 : 32'h10;
                end
                instr = {ca, imm, f3, r[15:11], `OP_SYSTEM};
            end
        endcase
    endtask

    task automatic check_outputs();
        check_pulse(trap, exp_trap, "trap");
        check_pulse(redirect_valid, exp_redirect, "redirect_valid");
        check_pulse(rd_we, exp_rd_we, "rd_we");
        if (exp_trap)
            check_info(trap_info, exp_info, "trap_info");
        if (exp_redirect)
            check_pc(redirect_pc, exp_rpc, "redirect_pc");
        if (exp_rd_we)
            check_word(rd_data, exp_rd, "rd_data");
    endtask

    initial begin
        seed = 32'h6a3e121d;
        rst_n = 1'b0;
        instr_valid = 1'b0;
        instr = '0;
        pc = '0;
        data_addr = '0;
        rs1_data = '0;
        m_mstatus = `MSTATUS_CHECK;  // reset values
        m_mtvec = '0;
        m_mepc = '0;
        m_mcause = '0;
        exp_trap = 1'b0;
        exp_redirect = 1'b0;
        exp_rd_we = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        check_pulse(trap, 1'b0, "trap in reset");
        check_pulse(redirect_valid, 1'b0, "redirect_valid in reset");
        check_pulse(rd_we, 1'b0, "rd_we in reset");
        rst_n = 1'b1;
        for (int i = 0; i <= N_INSTR; i++) begin
            @(posedge clk);
            #1;
            check_outputs();
            if (i < N_INSTR)
                drive_random();
            else
                instr_valid = 1'b0;  // drain
            predict();
        end
        @(posedge clk);
        #1;
        check_outputs();
        if (i_trap_unit.i_trap_unit_sva.fail_count == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            $display("%0d assertion failures", i_trap_unit.i_trap_unit_sva.fail_count);
            $display("*** FAILED ***");
            $fatal(1, "assertions failed");
        end
    end

endmodule

// ==== list.f ====
+incdir+rtl
rtl/trap_pkg.sv
rtl/csr_bus_if.sv
rtl/except_checker.sv
rtl/csr_file.sv
rtl/trap_ctrl.sv
rtl/trap_unit.sv
test/trap_unit_sva.sv
test/trap_unit_tb.sv
